// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fabric_tb
FILELIST  ?= balance_fabric.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= All tests passed

SOURCES := $(wildcard source/*.sv source/*.svh dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation PASS"; \
	else \
		echo "simulation FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== balance_fabric.f ====
+incdir+source
source/fabric_pkg.sv
source/switch_2x2.sv
source/link_stage.sv
source/delivery_counters.sv
source/balance_fabric_top.sv
dv/fabric_tb.sv

// ==== dv/fabric_tb.sv ====
`timescale 1ns/1ps

`include "fabric_macros.svh"

module fabric_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int BURST_LEN    = 40;
    localparam int SINGLE_LIMIT = 50;
    localparam int BURST_LIMIT  = BURST_LEN * 20;
    localparam int FILL_CYCLES  = 20;
    localparam int DRAIN_LIMIT  = 100;
    // reset, drive and drain of every test plus about 80 cycles of apb traffic
    localparam int RUN_CYCLES   = 4 + 2 * SINGLE_LIMIT + 2 * BURST_LIMIT + FILL_CYCLES
                                  + DRAIN_LIMIT + 80;

    logic                  clk = 1'b0;
    logic                  rst_n;
    fabric_pkg::flit_t     in_flit   [`FAB_PORTS];
    fabric_pkg::credit_t   in_credit [`FAB_PORTS];
    fabric_pkg::flit_t     out_flit  [`FAB_PORTS];
    logic                  out_ready [`FAB_PORTS] = '{default: 1'b0};
    fabric_pkg::apb_req_t  apb;
    logic [`FAB_CNT_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;

    integer seed = 32'hcfc3;
    int errors = 0;
    int checks = 0;
    // 0 all sinks stalled, 1 all ready, 2 random
    int ready_mode = 1;

    // scoreboard indexed by item value {source, seq}
    int sent_count [256];
    int got_count  [256];
    int acc_cyc    [256];
    int dlv_cyc    [256];
    int tally      [`FAB_PORTS];
    int inj_total = 0;
    int rx_total = 0;
    int cycle = 0;
    logic       in_fire  [`FAB_PORTS];
    logic [5:0] next_seq [`FAB_PORTS];

    balance_fabric_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_flit   (in_flit),
        .in_credit (in_credit),
        .out_flit  (out_flit),
        .out_ready (out_ready),
        .apb       (apb),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk)
    begin
        for (int i = 0; i < `FAB_PORTS; i++)
        begin
            if (ready_mode == 2)
                out_ready[i] <= (($random(seed) & 3) != 0);
            else
                out_ready[i] <= (ready_mode == 1);
        end
    end

    // handshakes that complete on the next rising edge are sampled while stable
    always @(negedge clk)
    begin
        cycle++;
        for (int i = 0; i < `FAB_PORTS; i++)
        begin
            in_fire[i] = rst_n && in_flit[i].valid && in_credit[i].ready;
            if (in_fire[i])
            begin
                sent_count[in_flit[i].data]++;
                acc_cyc[in_flit[i].data] = cycle;
                inj_total++;
            end
            if (rst_n && out_flit[i].valid && out_ready[i])
            begin
                got_count[out_flit[i].data]++;
                dlv_cyc[out_flit[i].data] = cycle;
                tally[i]++;
                rx_total++;
            end
        end
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("** Error %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic set_sink_ready(input int mode);
        @(negedge clk);
        ready_mode = mode;
    endtask

    // offers n items per producer until all are taken or max_cycles pass
    task automatic drive_producers(input int n0, input int n1, input int n2, input int n3,
                                   input int max_cycles, output bit done);
        int remaining [4];
        int cycles;
        remaining = '{n0, n1, n2, n3};
        cycles    = 0;
        done      = 1'b0;
        while (!done && cycles < max_cycles)
        begin
            @(posedge clk);
            cycles++;
            done = 1'b1;
            for (int p = 0; p < `FAB_PORTS; p++)
            begin
                if (in_fire[p])
                begin
                    remaining[p]--;
                    next_seq[p]++;
                end
                if (remaining[p] > 0)
                begin
                    in_flit[p].valid <= 1'b1;
                    in_flit[p].data  <= {2'(p), next_seq[p]};
                    done = 1'b0;
                end
                else
                    in_flit[p] <= '0;
            end
        end
        if (!done)
        begin
            @(posedge clk);
            for (int p = 0; p < `FAB_PORTS; p++)
            begin
                if (in_fire[p])
                    next_seq[p]++;
                in_flit[p] <= '0;
            end
        end
    endtask

    task automatic wait_for_drain(input string name, input int limit);
        int cycles;
        cycles = 0;
        while (rx_total != inj_total && cycles < limit)
        begin
            @(posedge clk);
            cycles++;
        end
        if (rx_total != inj_total)
        begin
            errors++;
            $display("%s: %0d items still inside the fabric after %0d cycles", name,
                     inj_total - rx_total, limit);
        end
    endtask

    task automatic verify_scoreboard(input string name);
        for (int v = 0; v < 256; v++)
            compare_value($sformatf("%s item 0x%02h", name, v), sent_count[v], got_count[v]);
        compare_value({name, " total"}, inj_total, rx_total);
    endtask

    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [`FAB_CNT_W-1:0] wdata,
                              output logic [`FAB_CNT_W-1:0] rdata,
                              output logic err, output logic rdy);
        @(posedge clk);
        apb.psel    <= 1'b1;
        apb.penable <= 1'b0;
        apb.pwrite  <= write;
        apb.paddr   <= addr;
        apb.pwdata  <= wdata;
        @(posedge clk);
        apb.penable <= 1'b1;
        // access phase without wait states
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        rdy   = pready;
        @(posedge clk);
        apb <= '0;
    endtask

    task automatic read_register(input string name, input logic [7:0] addr,
                                 input int expected, input logic expected_err);
        logic [`FAB_CNT_W-1:0] rdata;
        logic                  err;
        logic                  rdy;
        apb_access(1'b0, addr, '0, rdata, err, rdy);
        compare_value($sformatf("%s read 0x%02h", name, addr), expected, rdata);
        compare_value($sformatf("%s pslverr 0x%02h", name, addr), expected_err, err);
        compare_value($sformatf("%s pready 0x%02h", name, addr), 1, rdy);
    endtask

    task automatic reset_values();
        @(negedge clk);
        for (int i = 0; i < `FAB_PORTS; i++)
        begin
            compare_value("reset out valid", 0, out_flit[i].valid);
            compare_value("reset in ready", 1, in_credit[i].ready);
        end
        compare_value("reset pslverr", 0, pslverr);
        compare_value("reset prdata", 0, prdata);
        for (int a = 0; a < 5; a++)
            read_register("reset", 8'(4 * a), 0, 1'b0);
    endtask

    task automatic single_item_latency();
        logic [7:0] item;
        int         rx_before;
        bit         done;
        item      = {2'd2, next_seq[2]};
        rx_before = rx_total;
        set_sink_ready(1);
        drive_producers(0, 0, 1, 0, SINGLE_LIMIT, done);
        compare_value("single_item sent", 1, done);
        wait_for_drain("single_item", SINGLE_LIMIT);
        compare_value("single_item received", 1, got_count[item]);
        compare_value("single_item deliveries", 1, rx_total - rx_before);
        // two link stages of one cycle each
        compare_value("single_item latency", 2, dlv_cyc[item] - acc_cyc[item]);
    endtask

    task automatic random_burst();
        int rx_before;
        bit done;
        rx_before = rx_total;
        set_sink_ready(2);
        drive_producers(BURST_LEN, BURST_LEN, BURST_LEN, BURST_LEN, BURST_LIMIT, done);
        if (!done)
        begin
            errors++;
            $display("random_burst: producers could not send all items in %0d cycles",
                     BURST_LIMIT);
        end
        wait_for_drain("random_burst", BURST_LIMIT);
        set_sink_ready(1);
        compare_value("random_burst received", 4 * BURST_LEN, rx_total - rx_before);
        verify_scoreboard("random_burst");
    endtask

    task automatic back_pressure();
        int inj_before;
        int rx_before;
        bit done;
        inj_before = inj_total;
        rx_before  = rx_total;
        set_sink_ready(0);
        // sixteen items offered to eight link stages
        drive_producers(4, 4, 4, 4, FILL_CYCLES, done);
        compare_value("back_pressure accepted", 8, inj_total - inj_before);
        @(negedge clk);
        for (int i = 0; i < `FAB_PORTS; i++)
            compare_value("back_pressure in ready", 0, in_credit[i].ready);
        set_sink_ready(1);
        wait_for_drain("back_pressure", DRAIN_LIMIT);
        compare_value("back_pressure delivered", 8, rx_total - rx_before);
        verify_scoreboard("back_pressure");
    endtask

    task automatic apb_status();
        logic [`FAB_CNT_W-1:0] rdata;
        logic                  err;
        logic                  rdy;
        for (int i = 0; i < `FAB_PORTS; i++)
            read_register("apb_status", 8'(4 * i), tally[i], 1'b0);
        read_register("apb_status", `FAB_ADDR_INJ, inj_total, 1'b0);
        apb_access(1'b1, `FAB_ADDR_OUT0, '1, rdata, err, rdy);
        compare_value("apb_status counter write pslverr", 1, err);
        // the rejected write leaves the counter untouched
        read_register("apb_status after counter write", `FAB_ADDR_OUT0, tally[0], 1'b0);
        apb_access(1'b1, `FAB_ADDR_CLR, '1, rdata, err, rdy);
        compare_value("apb_status clear pslverr", 0, err);
        for (int a = 0; a < 5; a++)
            read_register("apb_status cleared", 8'(4 * a), 0, 1'b0);
        read_register("apb_status bad address", 8'h20, 0, 1'b1);
    endtask

    initial
    begin
        rst_n <= 1'b0;
        apb   <= '0;
        for (int i = 0; i < `FAB_PORTS; i++)
        begin
            in_flit[i]  <= '0;
            next_seq[i] = '0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        reset_values();
        single_item_latency();
        random_burst();
        back_pressure();
        apb_status();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    initial
    begin
        #(RUN_CYCLES * 2 * CLK_PERIOD);
        $display("watchdog: the run did not finish within %0d cycles", RUN_CYCLES * 2);
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== source/balance_fabric_top.sv ====
`timescale 1ns/1ps

`include "fabric_macros.svh"

module balance_fabric_top (
    input  logic                  clk,
    input  logic                  rst_n,

    input  fabric_pkg::flit_t     in_flit   [`FAB_PORTS],
    output fabric_pkg::credit_t   in_credit [`FAB_PORTS],

    output fabric_pkg::flit_t     out_flit  [`FAB_PORTS],
    input  logic                  out_ready [`FAB_PORTS],

    input  fabric_pkg::apb_req_t  apb,
    output logic [`FAB_CNT_W-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr
);

    // first-stage switch outputs, index 2*switch + output
    fabric_pkg::flit_t   s_out        [`FAB_PORTS];
    fabric_pkg::credit_t s_out_credit [`FAB_PORTS];
    // second-stage switch inputs, index 2*switch + input
    fabric_pkg::flit_t   mid          [`FAB_PORTS];
    fabric_pkg::credit_t mid_credit   [`FAB_PORTS];
    // second-stage switch outputs, one per consumer port
    fabric_pkg::flit_t   t_out        [`FAB_PORTS];
    fabric_pkg::credit_t t_out_credit [`FAB_PORTS];
    // consumers have nothing downstream, so they report zero latency
    fabric_pkg::credit_t sink_credit  [`FAB_PORTS];

    logic [3:0] delivered;
    logic [3:0] injected;

    for (genvar g = 0; g < 2; g++)
    begin : g_stage1
        switch_2x2 u_s (
            .in0         (in_flit[2*g]),
            .in1         (in_flit[2*g+1]),
            .in0_credit  (in_credit[2*g]),
            .in1_credit  (in_credit[2*g+1]),
            .out0        (s_out[2*g]),
            .out1        (s_out[2*g+1]),
            .out0_credit (s_out_credit[2*g]),
            .out1_credit (s_out_credit[2*g+1])
        );
    end

    // butterfly: s<s>.out<o> feeds t<o>.in<s>
    for (genvar s = 0; s < 2; s++)
    begin : g_mid_s
        for (genvar o = 0; o < 2; o++)
        begin : g_mid_o
            link_stage u_link (
                .clk         (clk),
                .rst_n       (rst_n),
                .up          (s_out[2*s+o]),
                .up_credit   (s_out_credit[2*s+o]),
                .down        (mid[2*o+s]),
                .down_credit (mid_credit[2*o+s])
            );
        end
    end

    for (genvar g = 0; g < 2; g++)
    begin : g_stage2
        switch_2x2 u_t (
            .in0         (mid[2*g]),
            .in1         (mid[2*g+1]),
            .in0_credit  (mid_credit[2*g]),
            .in1_credit  (mid_credit[2*g+1]),
            .out0        (t_out[2*g]),
            .out1        (t_out[2*g+1]),
            .out0_credit (t_out_credit[2*g]),
            .out1_credit (t_out_credit[2*g+1])
        );
    end

    for (genvar i = 0; i < `FAB_PORTS; i++)
    begin : g_port
        assign sink_credit[i].ready   = out_ready[i];
        assign sink_credit[i].latency = '0;

        link_stage u_out_link (
            .clk         (clk),
            .rst_n       (rst_n),
            .up          (t_out[i]),
            .up_credit   (t_out_credit[i]),
            .down        (out_flit[i]),
            .down_credit (sink_credit[i])
        );

        // handshake strobes for the status block
        assign injected[i]  = in_flit[i].valid && in_credit[i].ready;
        assign delivered[i] = out_flit[i].valid && out_ready[i];
    end

    delivery_counters u_counters (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb       (apb),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .delivered (delivered),
        .injected  (injected)
    );

endmodule

// ==== source/delivery_counters.sv ====
`timescale 1ns/1ps

`include "fabric_macros.svh"

module delivery_counters (
    input  logic                  clk,
    input  logic                  rst_n,

    input  fabric_pkg::apb_req_t  apb,
    output logic [`FAB_CNT_W-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,

    input  logic [3:0]            delivered,
    input  logic [3:0]            injected
);

    localparam int CNT_W = `FAB_CNT_W;

    logic [CNT_W-1:0] out_cnt [4];
    logic [CNT_W-1:0] inj_cnt;
    logic [2:0]       inj_sum;

    logic             access;
    logic             addr_ok;
    logic             addr_is_cnt;
    logic             clear;
    logic [CNT_W-1:0] rdata_sel;

    // zero wait states
    assign access = apb.psel && apb.penable;
    assign pready = access;

    // number of producers that handed over an item this cycle
    always_comb
    begin
        inj_sum = '0;
        for (int i = 0; i < 4; i++)
            inj_sum = inj_sum + {2'b00, injected[i]};
    end

    // address decode and read mux
    always_comb
    begin
        rdata_sel = '0;
        addr_ok   = 1'b1;
        case (apb.paddr)
            `FAB_ADDR_OUT0: rdata_sel = out_cnt[0];
            `FAB_ADDR_OUT1: rdata_sel = out_cnt[1];
            `FAB_ADDR_OUT2: rdata_sel = out_cnt[2];
            `FAB_ADDR_OUT3: rdata_sel = out_cnt[3];
            `FAB_ADDR_INJ:  rdata_sel = inj_cnt;
            `FAB_ADDR_CLR:  rdata_sel = '0;
            default:        addr_ok   = 1'b0;
        endcase
    end

    assign addr_is_cnt = addr_ok && (apb.paddr != `FAB_ADDR_CLR);

    // counters are read only, only the clear register takes writes
    assign pslverr = access && (!addr_ok || (apb.pwrite && addr_is_cnt));
    assign prdata  = (access && !apb.pwrite) ? rdata_sel : '0;
    assign clear   = access && apb.pwrite && (apb.paddr == `FAB_ADDR_CLR);

    always_ff @(posedge clk)
    begin
        if (!rst_n || clear)
        begin
            for (int i = 0; i < 4; i++)
                out_cnt[i] <= '0;
            inj_cnt <= '0;
        end
        else
        begin
            for (int i = 0; i < 4; i++)
                out_cnt[i] <= out_cnt[i] + CNT_W'(delivered[i]);
            inj_cnt <= inj_cnt + CNT_W'(inj_sum);
        end
    end

endmodule

// ==== source/fabric_macros.svh ====
`ifndef FABRIC_MACROS_SVH
`define FABRIC_MACROS_SVH

// item payload width
`define FAB_DWIDTH 8

// latency estimate width, saturates at all ones
`define FAB_LAT_W 4

// producer ports and consumer ports
`define FAB_PORTS 4

// status counter width
`define FAB_CNT_W 16

// apb address map
`define FAB_ADDR_OUT0 8'h00
`define FAB_ADDR_OUT1 8'h04
`define FAB_ADDR_OUT2 8'h08
`define FAB_ADDR_OUT3 8'h0C
`define FAB_ADDR_INJ  8'h10
`define FAB_ADDR_CLR  8'h14

`endif

// ==== source/fabric_pkg.sv ====
`include "fabric_macros.svh"

package fabric_pkg;

    // forward half of a link, travels downstream
    typedef struct packed {
        logic                   valid;
        logic [`FAB_DWIDTH-1:0] data;
    } flit_t;

    // backward half of a link, travels upstream
    // latency is the estimated number of cycles an item waits past this point
    typedef struct packed {
        logic                  ready;
        logic [`FAB_LAT_W-1:0] latency;
    } credit_t;

    // apb request from the bus master
    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [7:0]            paddr;
        logic [`FAB_CNT_W-1:0] pwdata;
    } apb_req_t;

endpackage

// ==== source/link_stage.sv ====
`timescale 1ns/1ps

`include "fabric_macros.svh"

module link_stage (
    input  logic                clk,
    input  logic                rst_n,

    input  fabric_pkg::flit_t   up,
    output fabric_pkg::credit_t up_credit,

    output fabric_pkg::flit_t   down,
    input  fabric_pkg::credit_t down_credit
);

    localparam int LAT_W = `FAB_LAT_W;
    localparam logic [LAT_W-1:0] LAT_MAX = {LAT_W{1'b1}};

    logic                   full;
    logic [`FAB_DWIDTH-1:0] data_q;
    logic                   accept;
    // one extra bit catches the carry for saturation
    logic [LAT_W:0]         lat_inc;

    // room when empty, or when the held item leaves this cycle
    assign up_credit.ready = !full || down_credit.ready;
    assign accept          = up.valid && up_credit.ready;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            full <= 1'b0;
        else if (accept)
            // refill, possibly in the same cycle the old item drains
            full <= 1'b1;
        else if (down_credit.ready)
            full <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            data_q <= up.data;
    end

    assign down.valid = full;
    assign down.data  = data_q;

    // a held item adds one cycle of wait for anything arriving behind it
    assign lat_inc = {1'b0, down_credit.latency} + 1'b1;

    always_comb
    begin
        if (!full)
            up_credit.latency = down_credit.latency;
        else if (lat_inc[LAT_W])
            up_credit.latency = LAT_MAX;
        else
            up_credit.latency = lat_inc[LAT_W-1:0];
    end

endmodule

// ==== source/switch_2x2.sv ====
`timescale 1ns/1ps

`include "fabric_macros.svh"

module switch_2x2 (
    input  fabric_pkg::flit_t   in0,
    input  fabric_pkg::flit_t   in1,
    output fabric_pkg::credit_t in0_credit,
    output fabric_pkg::credit_t in1_credit,

    output fabric_pkg::flit_t   out0,
    output fabric_pkg::flit_t   out1,
    input  fabric_pkg::credit_t out0_credit,
    input  fabric_pkg::credit_t out1_credit
);

    // 1 when out1 reports the lower latency, ties go to out1
    logic                  min_is_out1;
    logic [`FAB_LAT_W-1:0] min_latency;
    // output the single valid input should take
    logic                  best_output;
    // 1 maps in0->out0 and in1->out1, 0 crosses them
    logic                  straight;

    always_comb
    begin
        if (out1_credit.latency > out0_credit.latency)
        begin
            min_is_out1 = 1'b0;
            min_latency = out0_credit.latency;
        end
        else
        begin
            min_is_out1 = 1'b1;
            min_latency = out1_credit.latency;
        end
    end

    // take the lower latency output if it can accept,
    // otherwise fall back to whichever side is ready
    always_comb
    begin
        casez ({min_is_out1, out0_credit.ready, out1_credit.ready})
            3'b001:  best_output = 1'b1;
            3'b01?:  best_output = 1'b0;
            3'b1?1:  best_output = 1'b1;
            3'b110:  best_output = 1'b0;
            default: best_output = 1'b0;
        endcase
    end

    always_comb
    begin
        if (in0.valid && in1.valid)
            straight = 1'b1;
        else if (in0.valid)
            // in0 alone, straight when out0 is the better side
            straight = ~best_output;
        else
            // in1 alone (or idle), straight when out1 is the better side
            straight = best_output;
    end

    // both inputs see the best estimate below this switch,
    // which keeps the estimates from diverging around a loop
    always_comb
    begin
        in0_credit.latency = min_latency;
        in1_credit.latency = min_latency;
    end

    // crossbar
    always_comb
    begin
        if (straight)
        begin
            out0             = in0;
            out1             = in1;
            in0_credit.ready = out0_credit.ready;
            in1_credit.ready = out1_credit.ready;
        end
        else
        begin
            out0             = in1;
            out1             = in0;
            in0_credit.ready = out1_credit.ready;
            in1_credit.ready = out0_credit.ready;
        end
    end

endmodule
